// File: sim/mem_checker.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module mem_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   stall,
    input mem_pkg::mem_wb_t       wb_out,
    input logic [`MEM_GPIO_W-1:0] gpio_out
);
    import mem_pkg::*;

    mem_wb_t                exp_q [$];      // Expected writeback structs, in issue order
    logic [`MEM_GPIO_W-1:0] gpio_q [$];     // Expected gpio_out once each access completes
    bit                     mem_q [$];      // Set for loads and stores that stall first
    string                  name_q [$];
    int                     errors = 0;
    int                     outputs = 0;
    logic                   stall_prev = 1'b0;

    task automatic push_expect(
        input string                  name,
        input mem_wb_t                wb,
        input logic [`MEM_GPIO_W-1:0] gpio,
        input bit                     is_mem
    );
        name_q.push_back(name);
        exp_q.push_back(wb);
        gpio_q.push_back(gpio);
        mem_q.push_back(is_mem);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_value(
        input string                test,
        input string                field,
        input logic [`MEM_XLEN-1:0] exp,
        input logic [`MEM_XLEN-1:0] act
    );
        if (act !== exp)
        begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test, field, exp, act);
        end
    endtask

    task automatic compare_output();
        mem_wb_t                exp;
        logic [`MEM_GPIO_W-1:0] gpio_exp;
        bit                     is_mem;
        string                  name;
        if (exp_q.size() == 0)
        begin
            errors++;
            $display("A writeback output appeared with no test waiting for it");
        end
        else
        begin
            exp      = exp_q.pop_front();
            gpio_exp = gpio_q.pop_front();
            is_mem   = mem_q.pop_front();
            name     = name_q.pop_front();
            outputs++;
            check_value(name, "alu_result", exp.alu_result, wb_out.alu_result);
            check_value(name, "load_data", exp.load_data, wb_out.load_data);
            check_value(name, "fault", exp.fault, wb_out.fault);
            check_value(name, "mem_to_reg", exp.mem_to_reg, wb_out.mem_to_reg);
            check_value(name, "reg_write", exp.reg_write, wb_out.reg_write);
            check_value(name, "reg_dest", exp.reg_dest, wb_out.reg_dest);
            check_value(name, "reg_data_src", exp.reg_data_src, wb_out.reg_data_src);
            check_value(name, "pc_src", exp.pc_src, wb_out.pc_src);
            check_value(name, "branch_target", exp.branch_target, wb_out.branch_target);
            check_value(name, "gpio_out", gpio_exp, gpio_out);
            if (stall_prev !== is_mem)
            begin
                errors++;
                $display("error %s stall before result: expected %b, actual %b",
                         name, is_mem, stall_prev);
            end
        end
    endtask

    task automatic final_check();
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d expected writeback outputs never appeared", exp_q.size());
        end
    endtask

    // Sampled on the falling edge half a cycle away from any DUT update
    always @(negedge clk)
    begin
        if (rst)
            stall_prev = 1'b0;
        else
        begin
            if (stall_prev && !stall && !wb_out.valid)
            begin
                errors++;
                $display("Stall fell without a writeback output");
            end
            if (wb_out.valid && stall)
            begin
                errors++;
                $display("Stall was still high while a writeback output was valid");
            end
            if (wb_out.valid)
                compare_output();
            stall_prev = stall;
        end
    end

endmodule

// File: sim/tb_mem_subsystem.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module tb_mem_subsystem;
    import mem_pkg::*;

    typedef struct packed
    {
        mem_op_e                op;
        logic [`MEM_XLEN-1:0]   addr;
        logic [`MEM_XLEN-1:0]   wdata;
        logic [`MEM_GPIO_W-1:0] gin;           // Driven on gpio_in with this entry
        logic [`MEM_XLEN-1:0]   exp_load;
        logic                   exp_fault;
    } vec_t;

    localparam int N_VEC      = 23;
    localparam int N_PAIRS    = 32;
    localparam int RAM_IDX_W  = $clog2(`MEM_RAM_WORDS);
    localparam int TIMEOUT_NS = (N_VEC + 64) * (4 + `MEM_RAM_WAIT) * 40 * 2;

    logic                   clk;
    logic                   rst;
    ex_mem_t                ex_in;
    logic                   stall;
    mem_wb_t                wb_out;
    logic [`MEM_GPIO_W-1:0] gpio_in;
    logic [`MEM_GPIO_W-1:0] gpio_out;

    vec_t                   vec_tab [N_VEC];
    string                  vec_name [N_VEC];
    int                     vec_count;
    logic [`MEM_XLEN-1:0]   ram_model [`MEM_RAM_WORDS];
    logic [`MEM_GPIO_W-1:0] gpio_model;        // gpio_out after the latest access
    logic [31:0]            lfsr_state;

    mem_subsystem i_dut (
        .clk      (clk),
        .rst      (rst),
        .ex_in    (ex_in),
        .stall    (stall),
        .wb_out   (wb_out),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    mem_checker i_check (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .wb_out   (wb_out),
        .gpio_out (gpio_out)
    );

    // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Control fields vary with the tag so every pass-through bit gets exercised
    function automatic ex_mem_t make_item(
        input mem_op_e              op,
        input logic [`MEM_XLEN-1:0] addr,
        input logic [`MEM_XLEN-1:0] wdata,
        input int                   tag
    );
        ex_mem_t item;
        item.op            = op;
        item.alu_result    = addr;
        item.store_data    = wdata;
        item.mem_to_reg    = (op == op_load);
        item.reg_write     = (op != op_store);
        item.reg_dest      = tag[4:0];
        item.reg_data_src  = tag[1];
        item.pc_src        = tag[2];
        item.branch_target = {16'(tag), 16'hC0DE};
        item.valid         = 1'b1;
        return item;
    endfunction

    function automatic mem_wb_t expect_wb(
        input ex_mem_t              item,
        input logic [`MEM_XLEN-1:0] load,
        input logic                 fault
    );
        mem_wb_t wb;
        wb.valid         = 1'b1;
        wb.alu_result    = item.alu_result;
        wb.load_data     = load;
        wb.mem_to_reg    = item.mem_to_reg;
        wb.reg_write     = item.reg_write;
        wb.reg_dest      = item.reg_dest;
        wb.reg_data_src  = item.reg_data_src;
        wb.pc_src        = item.pc_src;
        wb.branch_target = item.branch_target;
        wb.fault         = fault;
        return wb;
    endfunction

    task automatic update_gpio_model(input ex_mem_t item, input logic fault);
        logic [`MEM_XLEN-1:0] off;
        off = item.alu_result - `MEM_GPIO_BASE;
        if (item.op == op_store && !fault && item.alu_result >= `MEM_GPIO_BASE
            && item.alu_result < (`MEM_GPIO_BASE + `MEM_GPIO_SPAN))
        begin
            if (off[3:2] == 2'd0)
                gpio_model = item.store_data[`MEM_GPIO_W-1:0];
            else if (off[3:2] == 2'd2)
                gpio_model = gpio_model ^ item.store_data[`MEM_GPIO_W-1:0];   // Toggle
        end
    endtask

    task automatic add_vec(
        input string                  name,
        input mem_op_e                op,
        input logic [`MEM_XLEN-1:0]   addr,
        input logic [`MEM_XLEN-1:0]   wdata,
        input logic [`MEM_GPIO_W-1:0] gin,
        input logic [`MEM_XLEN-1:0]   exp_load,
        input logic                   exp_fault
    );
        vec_name[vec_count]          = name;
        vec_tab[vec_count].op        = op;
        vec_tab[vec_count].addr      = addr;
        vec_tab[vec_count].wdata     = wdata;
        vec_tab[vec_count].gin       = gin;
        vec_tab[vec_count].exp_load  = exp_load;
        vec_tab[vec_count].exp_fault = exp_fault;
        vec_count++;
    endtask

    task automatic fill_table();
        add_vec("alu_pass_a",       op_none,  32'h1234_5678, 32'h0, 8'h00, 32'h0, 0);
        add_vec("alu_pass_b",       op_none,  32'hFFFF_0001, 32'h0, 8'h00, 32'h0, 0);
        add_vec("ram_store_a",      op_store, 32'h0000_0010, 32'hDEAD_BEEF, 8'h00, 32'h0, 0);
        add_vec("ram_store_b",      op_store, 32'h0000_0014, 32'h0BAD_F00D, 8'h00, 32'h0, 0);
        add_vec("ram_load_a",       op_load,  32'h0000_0010, 32'h0, 8'h00, 32'hDEAD_BEEF, 0);
        add_vec("ram_load_b",       op_load,  32'h0000_0014, 32'h0, 8'h00, 32'h0BAD_F00D, 0);
        add_vec("ram_top_store",    op_store, 32'h0000_03FC, 32'h1357_9BDF, 8'h00, 32'h0, 0);
        add_vec("ram_top_load",     op_load,  32'h0000_03FC, 32'h0, 8'h00, 32'h1357_9BDF, 0);
        add_vec("gpio_out_store",   op_store, 32'h1000_0000, 32'h0000_00A5, 8'h3C, 32'h0, 0);
        add_vec("gpio_out_load",    op_load,  32'h1000_0000, 32'h0, 8'h3C, 32'h0000_00A5, 0);
        add_vec("gpio_toggle",      op_store, 32'h1000_0008, 32'h0000_000F, 8'h3C, 32'h0, 0);
        add_vec("gpio_toggle_out",  op_load,  32'h1000_0000, 32'h0, 8'h3C, 32'h0000_00AA, 0);
        add_vec("gpio_toggle_read", op_load,  32'h1000_0008, 32'h0, 8'h3C, 32'h0, 0);
        add_vec("gpio_in_load",     op_load,  32'h1000_0004, 32'h0, 8'h3C, 32'h0000_003C, 0);
        add_vec("gpio_in_write",    op_store, 32'h1000_0004, 32'hFFFF_FFFF, 8'h3C, 32'h0, 0);
        add_vec("gpio_in_reload",   op_load,  32'h1000_0004, 32'h0, 8'h3C, 32'h0000_003C, 0);
        add_vec("gpio_out_kept",    op_load,  32'h1000_0000, 32'h0, 8'h3C, 32'h0000_00AA, 0);
        add_vec("gpio_spare",       op_load,  32'h1000_000C, 32'h0, 8'h3C, 32'h0, 0);
        add_vec("unmapped_ram",     op_store, 32'h0000_0410, 32'hFFFF_FFFF, 8'h3C, 32'h0, 1);
        add_vec("unmapped_load",    op_load,  32'h2000_0000, 32'h0, 8'h3C, 32'h0, 1);
        add_vec("unmapped_gpio",    op_store, 32'h1000_0010, 32'h0000_00FF, 8'h3C, 32'h0, 1);
        add_vec("ram_unchanged",    op_load,  32'h0000_0010, 32'h0, 8'h3C, 32'hDEAD_BEEF, 0);
        add_vec("alu_pass_c",       op_none,  32'h0000_0010, 32'h0, 8'h3C, 32'h0, 0);
    endtask

    // Called on a rising edge; returns on the edge that captured the item
    task automatic run_item(
        input string                  name,
        input ex_mem_t                item,
        input logic [`MEM_GPIO_W-1:0] gin,
        input logic [`MEM_XLEN-1:0]   exp_load,
        input logic                   exp_fault
    );
        update_gpio_model(item, exp_fault);
        i_check.push_expect(name, expect_wb(item, exp_load, exp_fault), gpio_model,
                            item.op != op_none);
        ex_in   <= item;
        gpio_in <= gin;
        @(posedge clk);
        while (stall)
            @(posedge clk);
    endtask

    task automatic close_run(input bit timed_out);
        $display("Outputs checked %0d, errors %0d, outputs missing %0d",
                 i_check.outputs, i_check.errors, i_check.pending());
        if (!timed_out && i_check.errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    initial
    begin
        logic [RAM_IDX_W-1:0] widx;
        logic [`MEM_XLEN-1:0] wdata;
        logic [`MEM_XLEN-1:0] addr;
        rst        = 1'b1;
        ex_in      = '0;
        gpio_in    = '0;
        gpio_model = '0;
        lfsr_state = 32'h2395_8757;
        vec_count  = 0;
        fill_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < N_VEC; i++)
            run_item(vec_name[i],
                     make_item(vec_tab[i].op, vec_tab[i].addr, vec_tab[i].wdata, i),
                     vec_tab[i].gin, vec_tab[i].exp_load, vec_tab[i].exp_fault);
        // Random RAM traffic with each store read straight back
        for (int k = 0; k < N_PAIRS; k++)
        begin
            widx            = RAM_IDX_W'(take_bits(RAM_IDX_W));
            wdata           = take_bits(32);
            addr            = `MEM_RAM_BASE + {widx, 2'b00};
            ram_model[widx] = wdata;
            run_item($sformatf("lfsr_store_%0d", k), make_item(op_store, addr, wdata, k),
                     gpio_in, '0, 1'b0);
            run_item($sformatf("lfsr_load_%0d", k), make_item(op_load, addr, '0, k),
                     gpio_in, ram_model[widx], 1'b0);
        end
        ex_in <= '0;
        while (i_check.pending() > 0)
            @(posedge clk);
        repeat (4) @(posedge clk);                  // Catch any stray output
        i_check.final_check();
        close_run(1'b0);
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish, writeback outputs stopped arriving");
        close_run(1'b1);
    end

endmodule

// File: source/apb_interconnect.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module apb_interconnect (
    input  mem_pkg::apb_req_t apb_req,
    output mem_pkg::apb_rsp_t apb_rsp,
    output logic              ram_sel,
    output logic              gpio_sel,
    input  mem_pkg::apb_rsp_t ram_rsp,
    input  mem_pkg::apb_rsp_t gpio_rsp
);
    import mem_pkg::*;

    localparam logic [`MEM_XLEN-1:0] RAM_BYTES = `MEM_RAM_WORDS * 4;

    logic [`MEM_XLEN-1:0] ram_off;
    logic [`MEM_XLEN-1:0] gpio_off;
    logic                 ram_hit;
    logic                 gpio_hit;

    // Offsets wrap below the base, so one compare covers both bounds
    assign ram_off  = apb_req.paddr - `MEM_RAM_BASE;
    assign gpio_off = apb_req.paddr - `MEM_GPIO_BASE;
    assign ram_hit  = (ram_off < RAM_BYTES);
    assign gpio_hit = (gpio_off < `MEM_GPIO_SPAN);

    assign ram_sel  = apb_req.psel && ram_hit;
    assign gpio_sel = apb_req.psel && gpio_hit;

    always_comb
    begin
        if (ram_hit)
        begin
            apb_rsp = ram_rsp;
        end
        else if (gpio_hit)
        begin
            apb_rsp = gpio_rsp;
        end
        else
        begin
            // Unmapped address answers at once with an error and no data
            apb_rsp.prdata  = '0;
            apb_rsp.pready  = 1'b1;
            apb_rsp.pslverr = apb_req.psel && apb_req.penable;
        end
    end

    // Guards the address map against overlapping windows
    always_comb
    begin
        assert #0 ($onehot0({ram_sel, gpio_sel}));
    end

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module data_ram (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  mem_pkg::apb_req_t apb_req,
    output mem_pkg::apb_rsp_t apb_rsp
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`MEM_RAM_WORDS);
    localparam int CNT_W = $clog2(`MEM_RAM_WAIT + 2);

    logic [`MEM_XLEN-1:0] mem [`MEM_RAM_WORDS];
    logic [`MEM_XLEN-1:0] rdata_q;
    logic [`MEM_XLEN-1:0] offset;
    logic [IDX_W-1:0]     idx;
    logic [CNT_W-1:0]     wait_cnt;      // Access cycles seen so far
    logic                 access;
    logic                 ready;

    assign offset = apb_req.paddr - `MEM_RAM_BASE;
    assign idx    = offset[IDX_W+1:2];   // Word index without byte lanes
    assign access = psel && apb_req.penable;
    assign ready  = access && (wait_cnt == CNT_W'(`MEM_RAM_WAIT));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wait_cnt <= '0;
        end
        else if (ready || !access)
        begin
            wait_cnt <= '0;
        end
        else
        begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Synchronous read; address is stable from setup, so data is ready by pready
    always_ff @(posedge clk)
    begin
        if (ready && apb_req.pwrite)
        begin
            mem[idx] <= apb_req.pwdata;  // Commit on the completing edge
        end
        rdata_q <= mem[idx];
    end

    always_comb
    begin
        apb_rsp.prdata  = rdata_q;
        apb_rsp.pready  = ready;
        apb_rsp.pslverr = 1'b0;          // Every word in range is valid
    end

    // Access phase is bounded by the configured wait states
    assert property (@(posedge clk) disable iff (rst)
        (psel && !apb_req.penable) |=> ##[0:`MEM_RAM_WAIT] apb_rsp.pready);

endmodule

// File: source/gpio_regs.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module gpio_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  mem_pkg::apb_req_t      apb_req,
    output mem_pkg::apb_rsp_t      apb_rsp,
    input  logic [`MEM_GPIO_W-1:0] gpio_in,
    output logic [`MEM_GPIO_W-1:0] gpio_out
);
    import mem_pkg::*;

    logic [`MEM_GPIO_W-1:0] in_meta;     // First synchroniser stage
    logic [`MEM_GPIO_W-1:0] in_sync;
    logic [1:0]             reg_sel;
    logic                   wr_en;

    assign reg_sel = apb_req.paddr[3:2];
    assign wr_en   = psel && apb_req.penable && apb_req.pwrite;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            in_meta  <= '0;
            in_sync  <= '0;
            gpio_out <= '0;
        end
        else
        begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
            if (wr_en)
            begin
                case (reg_sel)
                    2'd0:    gpio_out <= apb_req.pwdata[`MEM_GPIO_W-1:0];
                    2'd2:    gpio_out <= gpio_out ^ apb_req.pwdata[`MEM_GPIO_W-1:0];
                    default: gpio_out <= gpio_out;    // Input register is read-only
                endcase
            end
        end
    end

    always_comb
    begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;          // No wait states
        apb_rsp.pslverr = 1'b0;
        case (reg_sel)
            2'd0:    apb_rsp.prdata[`MEM_GPIO_W-1:0] = gpio_out;
            2'd1:    apb_rsp.prdata[`MEM_GPIO_W-1:0] = in_sync;
            default: apb_rsp.prdata = '0;            // Toggle and spare read zero
        endcase
    end

endmodule

// File: source/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Datapath widths
`define MEM_XLEN        32              // Data and address width
`define MEM_REG_ADDR_W  5               // Register file index width

// Data RAM
`define MEM_RAM_WORDS   256             // Depth in 32-bit words
`define MEM_RAM_BASE    32'h0000_0000   // Byte base address
`define MEM_RAM_WAIT    2               // Extra access cycles per transfer

// GPIO block
`define MEM_GPIO_BASE   32'h1000_0000   // Byte base address
`define MEM_GPIO_SPAN   16              // Window size in bytes
`define MEM_GPIO_W      8               // Port width

`endif

// File: source/mem_pkg.sv
`include "mem_config.svh"

package mem_pkg;

    typedef enum logic [1:0]
    {
        op_none,
        op_load,
        op_store
    } mem_op_e;

    typedef enum logic [1:0]
    {
        st_idle,
        st_setup,                               // psel high, penable low
        st_access                               // psel and penable high until pready
    } apb_state_e;

    typedef struct packed
    {
        mem_op_e                     op;
        logic [`MEM_XLEN-1:0]        alu_result;    // Also the memory address
        logic [`MEM_XLEN-1:0]        store_data;
        logic                        mem_to_reg;
        logic                        reg_write;
        logic [`MEM_REG_ADDR_W-1:0]  reg_dest;
        logic                        reg_data_src;
        logic                        pc_src;
        logic [`MEM_XLEN-1:0]        branch_target;
        logic                        valid;
    } ex_mem_t;

    typedef struct packed
    {
        logic                        valid;
        logic [`MEM_XLEN-1:0]        alu_result;
        logic [`MEM_XLEN-1:0]        load_data;     // Zero unless a load
        logic                        mem_to_reg;
        logic                        reg_write;
        logic [`MEM_REG_ADDR_W-1:0]  reg_dest;
        logic                        reg_data_src;
        logic                        pc_src;
        logic [`MEM_XLEN-1:0]        branch_target;
        logic                        fault;         // Bus error on this access
    } mem_wb_t;

    typedef struct packed
    {
        logic                        psel;
        logic                        penable;
        logic                        pwrite;
        logic [`MEM_XLEN-1:0]        paddr;
        logic [`MEM_XLEN-1:0]        pwdata;
    } apb_req_t;

    typedef struct packed
    {
        logic [`MEM_XLEN-1:0]        prdata;
        logic                        pready;
        logic                        pslverr;
    } apb_rsp_t;

endpackage

// File: source/mem_stage.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module mem_stage (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::ex_mem_t  ex_in,
    output logic              stall,
    output mem_pkg::apb_req_t apb_req,
    input  mem_pkg::apb_rsp_t apb_rsp,
    output mem_pkg::mem_wb_t  wb_out
);
    import mem_pkg::*;

    ex_mem_t    ex_q;           // Held copy of the captured instruction
    apb_state_e state;
    logic       capture;
    logic       is_mem_op;
    logic       done;

    // Build the writeback struct from an execute struct and bus result
    function automatic mem_wb_t make_wb(
        input ex_mem_t              ex,
        input logic [`MEM_XLEN-1:0] rdata,
        input logic                 err
    );
        mem_wb_t wb;
        wb.valid         = 1'b1;
        wb.alu_result    = ex.alu_result;
        wb.load_data     = rdata;
        wb.mem_to_reg    = ex.mem_to_reg;
        wb.reg_write     = ex.reg_write;
        wb.reg_dest      = ex.reg_dest;
        wb.reg_data_src  = ex.reg_data_src;
        wb.pc_src        = ex.pc_src;
        wb.branch_target = ex.branch_target;
        wb.fault         = err;
        return wb;
    endfunction

    assign capture   = ex_in.valid && !stall;                 // Input ignored while stalled
    assign is_mem_op = (ex_in.op == op_load) || (ex_in.op == op_store);
    assign done      = (state == st_access) && apb_rsp.pready;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_q <= '0;
        end
        else if (capture)
        begin
            ex_q <= ex_in;
        end
    end

    // Requester FSM; idle with stall high means a request is waiting to start
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= st_idle;
            stall <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (capture && is_mem_op)
                        stall <= 1'b1;
                    else if (stall)
                        state <= st_setup;
                end
                st_setup:
                begin
                    state <= st_access;
                end
                st_access:
                begin
                    if (apb_rsp.pready)
                    begin
                        state <= st_idle;
                        stall <= 1'b0;                        // Falls with wb_out.valid
                    end
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Address and write data come straight from the held struct
    always_comb
    begin
        apb_req.psel    = (state == st_setup) || (state == st_access);
        apb_req.penable = (state == st_access);
        apb_req.pwrite  = (ex_q.op == op_store);
        apb_req.paddr   = ex_q.alu_result;
        apb_req.pwdata  = ex_q.store_data;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_out <= '0;
        end
        else if (capture && !is_mem_op)
        begin
            wb_out <= make_wb(ex_in, '0, 1'b0);               // Pass-through in one cycle
        end
        else if (done)
        begin
            wb_out <= make_wb(ex_q,
                              (ex_q.op == op_load) ? apb_rsp.prdata : '0,
                              apb_rsp.pslverr);
        end
        else
        begin
            wb_out.valid <= 1'b0;
        end
    end

    // A transfer always opens with a setup cycle
    assert property (@(posedge clk) disable iff (rst)
        $rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel));

    // Request fields stay put until the completer answers
    assert property (@(posedge clk) disable iff (rst)
        (apb_req.psel && !(apb_req.penable && apb_rsp.pready))
            |=> $stable(apb_req.paddr) && $stable(apb_req.pwdata));

endmodule

// File: source/mem_subsystem.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module mem_subsystem (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_pkg::ex_mem_t       ex_in,
    output logic                   stall,
    output mem_pkg::mem_wb_t       wb_out,
    input  logic [`MEM_GPIO_W-1:0] gpio_in,
    output logic [`MEM_GPIO_W-1:0] gpio_out
);
    import mem_pkg::*;

    apb_req_t apb_req;               // Shared by both completers
    apb_rsp_t apb_rsp;
    apb_rsp_t ram_rsp;
    apb_rsp_t gpio_rsp;
    logic     ram_sel;
    logic     gpio_sel;

    mem_stage i_stage (
        .clk     (clk),
        .rst     (rst),
        .ex_in   (ex_in),
        .stall   (stall),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .wb_out  (wb_out)
    );

    apb_interconnect i_interconnect (
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .ram_sel  (ram_sel),
        .gpio_sel (gpio_sel),
        .ram_rsp  (ram_rsp),
        .gpio_rsp (gpio_rsp)
    );

    data_ram i_ram (
        .clk     (clk),
        .rst     (rst),
        .psel    (ram_sel),
        .apb_req (apb_req),
        .apb_rsp (ram_rsp)
    );

    gpio_regs i_gpio (
        .clk      (clk),
        .rst      (rst),
        .psel     (gpio_sel),
        .apb_req  (apb_req),
        .apb_rsp  (gpio_rsp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

// File: verilog.f
+incdir+source
source/mem_pkg.sv
source/data_ram.sv
source/gpio_regs.sv
source/apb_interconnect.sv
source/mem_stage.sv
source/mem_subsystem.sv
sim/mem_checker.sv
sim/tb_mem_subsystem.sv
